//--- verilog.f
+incdir+dv
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/pipe_control.sv
hdl/fetch_stage.sv
hdl/branch_predictor.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/core_top.sv
dv/core_tb.sv

//--- run.sh
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module core_tb -f verilog.f -o core_tb_sim

./obj_dir/core_tb_sim | tee sim.log

if grep -q "TEST PASSED" sim.log; then
	echo "simulation ok"
else
	echo "simulation reported errors, see sim.log"
	exit 1
fi

//--- dv/core_tb_tasks.svh
`ifndef CORE_TB_TASKS_SVH
`define CORE_TB_TASKS_SVH

	// architectural state of the reference model
	rv_isa_pkg::word_t model_regs [32] = '{default: '0};
	core_pkg::ctr_t    model_ctrs [core_pkg::BP_ENTRIES];

	//****************************************
	// instruction encoders
	//****************************************
	function automatic rv_isa_pkg::word_t make_r(logic [6:0] f7, int rd, int rs1, int rs2);
		return {f7, rs2[4:0], rs1[4:0], rv_isa_pkg::F3_ADD_SUB, rd[4:0], rv_isa_pkg::OPC_OP};
	endfunction

	function automatic rv_isa_pkg::word_t make_add(int rd, int rs1, int rs2);
		return make_r(7'd0, rd, rs1, rs2);
	endfunction

	function automatic rv_isa_pkg::word_t make_sub(int rd, int rs1, int rs2);
		return make_r(rv_isa_pkg::F7_SUB, rd, rs1, rs2);
	endfunction

	function automatic rv_isa_pkg::word_t make_addi(int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], rv_isa_pkg::F3_ADD_SUB, rd[4:0], rv_isa_pkg::OPC_OP_IMM};
	endfunction

	// b-type, offset in bytes
	function automatic rv_isa_pkg::word_t make_branch(logic [2:0] f3, int rs1, int rs2, int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11],
			rv_isa_pkg::OPC_BRANCH};
	endfunction

	task automatic add_instr(rv_isa_pkg::word_t w);
		prog_mem[prog_len[5:0]] = w;
		prog_len++;
	endtask

	//****************************************
	// reference model
	//****************************************
	task automatic run_model();
		rv_isa_pkg::pc_t   pc;
		rv_isa_pkg::pc_t   npc;
		rv_isa_pkg::pc_t   pred_npc;
		rv_isa_pkg::word_t instr;
		rv_isa_pkg::word_t a;
		rv_isa_pkg::word_t b;
		rv_isa_pkg::word_t res;
		rv_isa_pkg::word_t imm;
		logic [2:0]        f3;
		logic [3:0]        idx;
		logic              wr;
		int                steps;
		core_pkg::commit_t rec;
		pc    = core_pkg::RESET_PC;
		steps = 0;
		while ((pc < rv_isa_pkg::pc_t'(prog_len * 4)) && (steps < 200)) begin
			instr = prog_mem[pc[7:2]];
			f3    = instr[14:12];
			a     = model_regs[instr[19:15]];
			b     = model_regs[instr[24:20]];
			res   = '0;
			wr    = 1'b0;
			npc   = pc + 32'd4;
			rec        = '0;
			rec.valid  = 1'b1;
			rec.pc     = pc;
			rec.rd     = instr[11:7];
			case (instr[6:0])
				rv_isa_pkg::OPC_OP: begin
					if ((f3 == rv_isa_pkg::F3_ADD_SUB) && (instr[31:25] == 7'd0)) begin
						res = a + b;
						wr  = 1'b1;
					end else if ((f3 == rv_isa_pkg::F3_ADD_SUB) &&
						(instr[31:25] == rv_isa_pkg::F7_SUB)) begin
						res = a - b;
						wr  = 1'b1;
					end
				end
				rv_isa_pkg::OPC_OP_IMM: begin
					if (f3 == rv_isa_pkg::F3_ADD_SUB) begin
						res = a + {{20{instr[31]}}, instr[31:20]};
						wr  = 1'b1;
					end
				end
				rv_isa_pkg::OPC_BRANCH: begin
					if ((f3 == rv_isa_pkg::F3_BEQ) || (f3 == rv_isa_pkg::F3_BNE)) begin
						imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
							instr[11:8], 1'b0};
						// counter indexed by pc bits 5 to 2
						idx            = pc[5:2];
						rec.is_branch  = 1'b1;
						rec.pred_taken = model_ctrs[idx][1];
						rec.taken      = (f3 == rv_isa_pkg::F3_BNE) ? (a != b) : (a == b);
						pred_npc       = rec.pred_taken ? (pc + imm) : (pc + 32'd4);
						if (rec.taken) begin
							npc = pc + imm;
						end
						rec.mispredict = (npc != pred_npc);
						if (rec.taken && (model_ctrs[idx] != 2'd3)) begin
							model_ctrs[idx]++;
						end else if (!rec.taken && (model_ctrs[idx] != 2'd0)) begin
							model_ctrs[idx]--;
						end
					end
				end
				default: begin
				end
			endcase
			rec.we    = wr && (instr[11:7] != 5'd0);
			rec.wdata = res;
			if (rec.we) begin
				model_regs[instr[11:7]] = res;
			end
			exp_q.push_back(rec);
			pc = npc;
			steps++;
		end
	endtask

	task automatic run_and_check();
		apply_reset();
		run_model();
		expect_commits();
		end_test();
	endtask

	//****************************************
	// directed tests
	//****************************************
	task automatic test_reset();
		int cycles;
		start_test("reset", 1'b0);
		add_instr(make_addi(1, 0, 1));
		apply_reset();
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (commit.valid) begin
				report_failure("commit valid before the first request");
			end
		end while (!imem_req && (cycles < 10));
		if (!imem_req) begin
			report_failure("no instruction request after reset");
		end else begin
			compare_value("cycles to first request", 32'd2, cycles);
			compare_value("first request address", core_pkg::RESET_PC, imem_addr);
		end
		end_test();
	endtask

	task automatic test_straight_line();
		start_test("straight_line", 1'b0);
		add_instr(make_addi(1, 0, 5));
		add_instr(make_addi(2, 0, -3));
		add_instr(make_add(3, 1, 2));
		add_instr(make_sub(4, 1, 2));
		// results to x0 must not be written
		add_instr(make_addi(0, 1, 7));
		add_instr(make_add(0, 3, 4));
		add_instr(make_sub(5, 2, 1));
		run_and_check();
	endtask

	task automatic test_dependencies();
		start_test("dependencies", 1'b0);
		add_instr(make_addi(1, 0, 1));
		add_instr(make_add(1, 1, 1));
		add_instr(make_add(1, 1, 1));
		add_instr(make_addi(2, 1, 100));
		add_instr(make_sub(3, 2, 1));
		add_instr(make_add(3, 3, 3));
		add_instr(make_addi(4, 3, -1));
		run_and_check();
	endtask

	task automatic test_bne_loop();
		start_test("bne_loop", 1'b0);
		add_instr(make_addi(1, 0, 5));
		add_instr(make_addi(2, 0, 0));
		add_instr(make_addi(2, 2, 3));
		add_instr(make_addi(1, 1, -1));
		add_instr(make_branch(rv_isa_pkg::F3_BNE, 1, 0, -8));
		add_instr(make_addi(3, 2, 0));
		run_and_check();
	endtask

	task automatic test_random_ack();
		start_test("random_ack", 1'b1);
		add_instr(make_addi(1, 0, 3));
		add_instr(make_addi(2, 0, 3));
		add_instr(make_branch(rv_isa_pkg::F3_BEQ, 1, 2, 8));
		add_instr(make_addi(5, 0, 99));
		add_instr(make_addi(3, 0, 1));
		add_instr(make_branch(rv_isa_pkg::F3_BEQ, 1, 3, 8));
		add_instr(make_addi(7, 0, 7));
		add_instr(make_addi(6, 0, 4));
		// inner loop, exit beq then an always-taken beq back
		add_instr(make_addi(6, 6, -1));
		add_instr(make_addi(7, 7, 2));
		add_instr(make_branch(rv_isa_pkg::F3_BEQ, 6, 0, 8));
		add_instr(make_branch(rv_isa_pkg::F3_BEQ, 0, 0, -12));
		add_instr(make_addi(8, 7, 0));
		run_and_check();
	endtask

`endif

//--- dv/core_tb.sv
module core_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int unsigned SEED       = 32'h6db3_2825;
	localparam int          PROG_WORDS = 64;

	logic              clk;
	logic              arst_n;
	logic              imem_req;
	rv_isa_pkg::pc_t   imem_addr;
	logic              imem_ack;
	rv_isa_pkg::word_t imem_rdata;
	core_pkg::commit_t commit;

	rv_isa_pkg::word_t prog_mem [PROG_WORDS];
	int                prog_len;
	logic              rand_delays;
	core_pkg::commit_t got_q [$];
	core_pkg::commit_t exp_q [$];

	string             cur_test;
	int                err_base;
	int                errors;
	int                tests_run;
	int                tests_failed;

	// responder state
	logic              resp_busy;
	int unsigned       resp_wait;

	// port values one cycle back
	logic              prev_req;
	rv_isa_pkg::pc_t   prev_addr;

	core_top DUT (
		.clk_i        (clk),
		.arst_n_i     (arst_n),
		.imem_req_o   (imem_req),
		.imem_addr_o  (imem_addr),
		.imem_ack_i   (imem_ack),
		.imem_rdata_i (imem_rdata),
		.commit_o     (commit)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	`include "core_tb_tasks.svh"

	//****************************************
	// instruction memory responder
	//****************************************
	function automatic rv_isa_pkg::word_t read_program(rv_isa_pkg::pc_t addr);
		if (addr < rv_isa_pkg::pc_t'(prog_len * 4)) begin
			return prog_mem[addr[7:2]];
		end
		return rv_isa_pkg::NOP_INSTR;
	endfunction

	always @(posedge clk) begin
		if (!arst_n) begin
			imem_ack  <= 1'b0;
			resp_busy = 1'b0;
		end else if (imem_ack) begin
			// release phase
			if (!imem_req) begin
				imem_ack <= 1'b0;
			end
		end else if (imem_req) begin
			if (!resp_busy) begin
				resp_busy = 1'b1;
				resp_wait = rand_delays ? ($urandom % 5) : 0;
			end
			if (resp_wait == 0) begin
				imem_ack   <= 1'b1;
				imem_rdata <= read_program(imem_addr);
				resp_busy  = 1'b0;
			end else begin
				resp_wait--;
			end
		end
	end

	//****************************************
	// commit monitor and port checks
	//****************************************
	always @(negedge clk) begin
		if (arst_n) begin
			if (commit.valid) begin
				got_q.push_back(commit);
			end
			if (imem_req && !prev_req && imem_ack) begin
				report_failure("request raised while acknowledge was still high");
			end
			if (imem_req && prev_req && (imem_addr != prev_addr)) begin
				report_failure("address changed during an open request");
			end
			if (!imem_req && prev_req && !imem_ack) begin
				report_failure("request dropped before the acknowledge arrived");
			end
		end
		prev_req  = imem_req;
		prev_addr = imem_addr;
	end

	task automatic report_failure(string msg);
		errors++;
		$display("%s: %s", cur_test, msg);
	endtask

	task automatic compare_value(string what, logic [31:0] exp, logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("mismatch in %s, %s: expected %h, actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		arst_n <= 1'b0;
		repeat (5) begin
			@(negedge clk);
			if (commit.valid || imem_req) begin
				report_failure("commit valid or request high during reset");
			end
			@(posedge clk);
		end
		arst_n <= 1'b1;
		got_q.delete();
	endtask

	// scoreboard compares commits with the model in order
	task automatic expect_commits();
		int                n;
		int                waited;
		string             tag;
		core_pkg::commit_t exp;
		core_pkg::commit_t got;
		n      = exp_q.size();
		waited = 0;
		while ((got_q.size() < n) && (waited < 20 * n + 50)) begin
			@(posedge clk);
			waited++;
		end
		if (got_q.size() < n) begin
			report_failure($sformatf("timed out with %0d of %0d commits", got_q.size(), n));
		end
		while ((exp_q.size() > 0) && (got_q.size() > 0)) begin
			exp = exp_q.pop_front();
			got = got_q.pop_front();
			tag = $sformatf("commit at pc %h", exp.pc);
			compare_value({tag, " pc"}, exp.pc, got.pc);
			compare_value({tag, " is_branch"}, 32'(exp.is_branch), 32'(got.is_branch));
			compare_value({tag, " pred_taken"}, 32'(exp.pred_taken), 32'(got.pred_taken));
			compare_value({tag, " taken"}, 32'(exp.taken), 32'(got.taken));
			compare_value({tag, " mispredict"}, 32'(exp.mispredict), 32'(got.mispredict));
			compare_value({tag, " we"}, 32'(exp.we), 32'(got.we));
			compare_value({tag, " rd"}, 32'(exp.rd), 32'(got.rd));
			if (!exp.is_branch) begin
				compare_value({tag, " wdata"}, exp.wdata, got.wdata);
			end
		end
		exp_q.delete();
	endtask

	task automatic start_test(string name, logic rand_ack);
		cur_test    = name;
		err_base    = errors;
		rand_delays = rand_ack;
		prog_len    = 0;
		model_ctrs  = '{default: core_pkg::CTR_RESET};
	endtask

	task automatic end_test();
		tests_run++;
		if (errors > err_base) begin
			tests_failed++;
			$display("%s: failed with %0d errors", cur_test, errors - err_base);
		end else begin
			$display("%s: ok", cur_test);
		end
	endtask

	initial begin
		int unsigned seed_ret;
		arst_n       = 1'b0;
		imem_ack     = 1'b0;
		imem_rdata   = rv_isa_pkg::NOP_INSTR;
		rand_delays  = 1'b0;
		prog_len     = 0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		cur_test     = "setup";
		seed_ret     = $urandom(SEED);

		test_reset();
		test_straight_line();
		test_dependencies();
		test_bne_loop();
		test_random_ack();

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- hdl/core_top.sv
module core_top (
	input  logic                  clk_i,
	input  logic                  arst_n_i,
	output logic                  imem_req_o,
	output rv_isa_pkg::pc_t       imem_addr_o,
	input  logic                  imem_ack_i,
	input  rv_isa_pkg::word_t     imem_rdata_i,
	output core_pkg::commit_t     commit_o
);

	logic                 fetch_done;
	logic                 fetch_stale;
	logic                 kill_decode;
	core_pkg::redirect_t  redirect;
	rv_isa_pkg::pc_t      bp_pc;
	logic                 bp_taken;
	core_pkg::fd_t        fd;
	core_pkg::de_t        de;
	logic                 wb_we;
	rv_isa_pkg::reg_idx_t wb_rd;
	rv_isa_pkg::word_t    wb_data;

	//****************************************
	// control and fetch
	//****************************************
	pipe_control u_pipe_control (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.imem_req_o    (imem_req_o),
		.imem_ack_i    (imem_ack_i),
		.redirect_i    (redirect),
		.fetch_done_o  (fetch_done),
		.fetch_stale_o (fetch_stale),
		.kill_decode_o (kill_decode)
	);

	fetch_stage u_fetch_stage (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.imem_addr_o   (imem_addr_o),
		.imem_rdata_i  (imem_rdata_i),
		.fetch_done_i  (fetch_done),
		.fetch_stale_i (fetch_stale),
		.kill_i        (kill_decode),
		.redirect_i    (redirect),
		.bp_pc_o       (bp_pc),
		.bp_taken_i    (bp_taken),
		.fd_o          (fd)
	);

	branch_predictor u_branch_predictor (
		.clk_i        (clk_i),
		.arst_n_i     (arst_n_i),
		.lookup_pc_i  (bp_pc),
		.pred_taken_o (bp_taken),
		.redirect_i   (redirect)
	);

	//****************************************
	// decode and execute
	//****************************************
	decode_stage u_decode_stage (
		.clk_i     (clk_i),
		.arst_n_i  (arst_n_i),
		.fd_i      (fd),
		.kill_i    (kill_decode),
		.wb_we_i   (wb_we),
		.wb_rd_i   (wb_rd),
		.wb_data_i (wb_data),
		.de_o      (de)
	);

	execute_stage u_execute_stage (
		.clk_i      (clk_i),
		.arst_n_i   (arst_n_i),
		.de_i       (de),
		.wb_we_o    (wb_we),
		.wb_rd_o    (wb_rd),
		.wb_data_o  (wb_data),
		.redirect_o (redirect),
		.commit_o   (commit_o)
	);

endmodule

//--- hdl/execute_stage.sv
module execute_stage (
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  core_pkg::de_t        de_i,
	output logic                 wb_we_o,
	output rv_isa_pkg::reg_idx_t wb_rd_o,
	output rv_isa_pkg::word_t    wb_data_o,
	output core_pkg::redirect_t  redirect_o,
	output core_pkg::commit_t    commit_o
);

	rv_isa_pkg::word_t alu_res;
	rv_isa_pkg::pc_t   br_target;
	rv_isa_pkg::pc_t   actual_npc;
	logic              taken;
	logic              mispredict;
	core_pkg::commit_t commit_q;

	always_comb begin
		case (de_i.alu_op)
			core_pkg::ALU_ADD: alu_res = de_i.rs1_val + de_i.rs2_val;
			core_pkg::ALU_SUB: alu_res = de_i.rs1_val - de_i.rs2_val;
			default:           alu_res = '0;
		endcase
	end

	//****************************************
	// branch resolution
	//****************************************
	assign taken = de_i.is_branch &&
		(de_i.br_ne ? (de_i.rs1_val != de_i.rs2_val) : (de_i.rs1_val == de_i.rs2_val));

	assign br_target  = de_i.pc + de_i.imm;
	assign actual_npc = taken ? br_target : (de_i.pc + 32'd4);
	assign mispredict = de_i.valid && (actual_npc != de_i.pred_npc);

	assign redirect_o.valid       = mispredict;
	assign redirect_o.target      = actual_npc;
	assign redirect_o.train_valid = de_i.valid && de_i.is_branch;
	assign redirect_o.train_pc    = de_i.pc;
	assign redirect_o.train_taken = taken;

	// write port, also the forward source for decode
	assign wb_we_o   = de_i.valid && de_i.we;
	assign wb_rd_o   = de_i.rd;
	assign wb_data_o = alu_res;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			commit_q <= '0;
		end else begin
			commit_q.valid      <= de_i.valid;
			commit_q.pc         <= de_i.pc;
			commit_q.is_branch  <= de_i.is_branch;
			commit_q.pred_taken <= de_i.pred_taken;
			commit_q.taken      <= taken;
			commit_q.mispredict <= mispredict;
			commit_q.rd         <= de_i.rd;
			commit_q.we         <= wb_we_o;
			commit_q.wdata      <= alu_res;
		end
	end

	assign commit_o = commit_q;

	a_no_x0_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		wb_we_o |-> (wb_rd_o != '0));

	// fetch must predict fall-through for everything but a branch
	a_mispredict_on_branch: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		redirect_o.valid |-> de_i.is_branch);

endmodule

//--- hdl/decode_stage.sv
module decode_stage (
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  core_pkg::fd_t        fd_i,
	input  logic                 kill_i,
	input  logic                 wb_we_i,
	input  rv_isa_pkg::reg_idx_t wb_rd_i,
	input  rv_isa_pkg::word_t    wb_data_i,
	output core_pkg::de_t        de_o
);

	logic [6:0]           opcode;
	logic [2:0]           funct3;
	logic [6:0]           funct7;
	rv_isa_pkg::reg_idx_t rs1;
	rv_isa_pkg::reg_idx_t rs2;
	rv_isa_pkg::reg_idx_t rd;
	rv_isa_pkg::imm_t     imm_i;
	rv_isa_pkg::imm_t     imm_b;
	rv_isa_pkg::word_t    rs1_val;
	rv_isa_pkg::word_t    rs2_val;
	rv_isa_pkg::word_t    regs [1:31];
	logic                 wr_en;
	core_pkg::de_t        de_d;
	core_pkg::de_t        de_q;

	assign opcode = fd_i.instr[6:0];
	assign rd     = fd_i.instr[11:7];
	assign funct3 = fd_i.instr[14:12];
	assign rs1    = fd_i.instr[19:15];
	assign rs2    = fd_i.instr[24:20];
	assign funct7 = fd_i.instr[31:25];

	assign imm_i = {{20{fd_i.instr[31]}}, fd_i.instr[31:20]};
	assign imm_b = {{19{fd_i.instr[31]}}, fd_i.instr[31], fd_i.instr[7],
		fd_i.instr[30:25], fd_i.instr[11:8], 1'b0};

	//****************************************
	// register file with forwarding
	//****************************************
	// execute writes this cycle, so its port wins over the array
	assign rs1_val = (rs1 == '0) ? '0 :
		(wb_we_i && (wb_rd_i == rs1)) ? wb_data_i : regs[rs1];
	assign rs2_val = (rs2 == '0) ? '0 :
		(wb_we_i && (wb_rd_i == rs2)) ? wb_data_i : regs[rs2];

	always_ff @(posedge clk_i) begin
		if (wb_we_i && (wb_rd_i != '0)) begin
			regs[wb_rd_i] <= wb_data_i;
		end
	end

	always_comb begin
		de_d            = '0;
		wr_en           = 1'b0;
		de_d.valid      = fd_i.valid;
		de_d.pc         = fd_i.pc;
		de_d.pred_taken = fd_i.pred_taken;
		de_d.pred_npc   = fd_i.pred_npc;
		de_d.rs1_val    = rs1_val;
		de_d.rs2_val    = rs2_val;
		de_d.imm        = imm_b;
		de_d.rd         = rd;
		de_d.alu_op     = core_pkg::ALU_PASS_NONE;
		case (opcode)
			rv_isa_pkg::OPC_OP: begin
				if (funct3 == rv_isa_pkg::F3_ADD_SUB && funct7 == rv_isa_pkg::F7_SUB) begin
					de_d.alu_op = core_pkg::ALU_SUB;
					wr_en       = 1'b1;
				end else if (funct3 == rv_isa_pkg::F3_ADD_SUB && funct7 == 7'd0) begin
					de_d.alu_op = core_pkg::ALU_ADD;
					wr_en       = 1'b1;
				end
			end
			rv_isa_pkg::OPC_OP_IMM: begin
				if (funct3 == rv_isa_pkg::F3_ADD_SUB) begin
					// operand b carries the immediate
					de_d.alu_op  = core_pkg::ALU_ADD;
					de_d.rs2_val = imm_i;
					de_d.imm     = imm_i;
					wr_en        = 1'b1;
				end
			end
			rv_isa_pkg::OPC_BRANCH: begin
				if (funct3 == rv_isa_pkg::F3_BEQ || funct3 == rv_isa_pkg::F3_BNE) begin
					de_d.is_branch = 1'b1;
					de_d.br_ne     = (funct3 == rv_isa_pkg::F3_BNE);
				end
			end
			default: begin
			end
		endcase
		// x0 is never written
		de_d.we = wr_en && (rd != '0);
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			de_q <= '0;
		end else begin
			de_q       <= de_d;
			de_q.valid <= de_d.valid && !kill_i;
		end
	end

	assign de_o = de_q;

endmodule

//--- hdl/branch_predictor.sv
module branch_predictor (
	input  logic                clk_i,
	input  logic                arst_n_i,
	input  rv_isa_pkg::pc_t     lookup_pc_i,
	output logic                pred_taken_o,
	input  core_pkg::redirect_t redirect_i
);

	core_pkg::ctr_t                table_q [core_pkg::BP_ENTRIES];
	logic [core_pkg::BP_IDX_W-1:0] lookup_idx;
	logic [core_pkg::BP_IDX_W-1:0] train_idx;
	core_pkg::ctr_t                train_ctr;

	// index from word address bits
	assign lookup_idx = lookup_pc_i[core_pkg::BP_IDX_W+1:2];
	assign train_idx  = redirect_i.train_pc[core_pkg::BP_IDX_W+1:2];

	// upper bit set means taken
	assign pred_taken_o = table_q[lookup_idx][1];

	assign train_ctr = table_q[train_idx];

	//****************************************
	// saturating update from execute
	//****************************************
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < core_pkg::BP_ENTRIES; i++) begin
				table_q[i] <= core_pkg::CTR_RESET;
			end
		end else if (redirect_i.train_valid) begin
			if (redirect_i.train_taken && (train_ctr != 2'd3)) begin
				table_q[train_idx] <= train_ctr + 2'd1;
			end else if (!redirect_i.train_taken && (train_ctr != 2'd0)) begin
				table_q[train_idx] <= train_ctr - 2'd1;
			end
		end
	end

endmodule

//--- hdl/fetch_stage.sv
module fetch_stage (
	input  logic                clk_i,
	input  logic                arst_n_i,
	output rv_isa_pkg::pc_t     imem_addr_o,
	input  rv_isa_pkg::word_t   imem_rdata_i,
	input  logic                fetch_done_i,
	input  logic                fetch_stale_i,
	input  logic                kill_i,
	input  core_pkg::redirect_t redirect_i,
	output rv_isa_pkg::pc_t     bp_pc_o,
	input  logic                bp_taken_i,
	output core_pkg::fd_t       fd_o
);

	rv_isa_pkg::pc_t   pc_q;
	rv_isa_pkg::pc_t   pend_target;
	rv_isa_pkg::word_t br_offset;
	rv_isa_pkg::pc_t   pred_npc;
	logic              is_branch;
	logic              pred_taken;
	logic              accept;
	core_pkg::fd_t     fd_q;

	assign imem_addr_o = pc_q;
	assign bp_pc_o     = pc_q;

	//****************************************
	// predecode of the returned word
	//****************************************
	assign is_branch = (imem_rdata_i[6:0] == rv_isa_pkg::OPC_BRANCH) &&
		((imem_rdata_i[14:12] == rv_isa_pkg::F3_BEQ) ||
		 (imem_rdata_i[14:12] == rv_isa_pkg::F3_BNE));

	// b-type offset
	assign br_offset = {{19{imem_rdata_i[31]}}, imem_rdata_i[31], imem_rdata_i[7],
		imem_rdata_i[30:25], imem_rdata_i[11:8], 1'b0};

	assign pred_taken = is_branch && bp_taken_i;
	assign pred_npc   = pred_taken ? (pc_q + br_offset) : (pc_q + 32'd4);
	assign accept     = fetch_done_i && !fetch_stale_i;

	// next fetch address
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_q <= core_pkg::RESET_PC;
		end else if (fetch_done_i) begin
			if (!fetch_stale_i) begin
				pc_q <= pred_npc;
			end else if (redirect_i.valid) begin
				pc_q <= redirect_i.target;
			end else begin
				pc_q <= pend_target;
			end
		end else if (redirect_i.valid && !fetch_stale_i) begin
			// no request open, address may change now
			pc_q <= redirect_i.target;
		end
	end

	// target held until the stale response is gone
	always_ff @(posedge clk_i) begin
		if (redirect_i.valid) begin
			pend_target <= redirect_i.target;
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			fd_q <= '0;
		end else begin
			fd_q.valid <= accept && !kill_i;
			if (accept) begin
				fd_q.pc         <= pc_q;
				fd_q.instr      <= imem_rdata_i;
				fd_q.pred_taken <= pred_taken;
				fd_q.pred_npc   <= pred_npc;
			end
		end
	end

	assign fd_o = fd_q;

endmodule

//--- hdl/pipe_control.sv
module pipe_control (
	input  logic                clk_i,
	input  logic                arst_n_i,
	output logic                imem_req_o,
	input  logic                imem_ack_i,
	input  core_pkg::redirect_t redirect_i,
	output logic                fetch_done_o,
	output logic                fetch_stale_o,
	output logic                kill_decode_o
);

	core_pkg::fetch_state_e state_q;
	core_pkg::fetch_state_e state_d;
	logic                   stale_q;

	//****************************************
	// four-phase fetch handshake
	//****************************************
	always_comb begin
		state_d = state_q;
		unique case (state_q)
			core_pkg::FS_IDLE: begin
				state_d = core_pkg::FS_REQ;
			end
			core_pkg::FS_REQ: begin
				if (imem_ack_i) begin
					state_d = core_pkg::FS_RELEASE;
				end
			end
			core_pkg::FS_RELEASE: begin
				// wait for the memory to drop ack
				if (!imem_ack_i) begin
					state_d = core_pkg::FS_IDLE;
				end
			end
			default: begin
				state_d = core_pkg::FS_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= core_pkg::FS_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	assign imem_req_o   = (state_q == core_pkg::FS_REQ);
	assign fetch_done_o = imem_req_o && imem_ack_i;

	// response is stale once a redirect hit the open request
	assign fetch_stale_o = imem_req_o && (stale_q || redirect_i.valid);

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			stale_q <= 1'b0;
		end else if (fetch_done_o) begin
			stale_q <= 1'b0;
		end else if (imem_req_o && redirect_i.valid) begin
			stale_q <= 1'b1;
		end
	end

	// wrong-path instruction in decode dies with the redirect
	assign kill_decode_o = redirect_i.valid;

	a_req_after_ack_low: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		$rose(imem_req_o) |-> !imem_ack_i);

	a_req_held_until_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(state_q == core_pkg::FS_REQ) && !imem_ack_i |=> state_q == core_pkg::FS_REQ);

endmodule

//--- hdl/core_pkg.sv
package core_pkg;

	// first fetch address
	localparam rv_isa_pkg::pc_t RESET_PC = 32'h0000_0000;

	//****************************************
	// bimodal predictor
	//****************************************
	localparam int BP_ENTRIES = 16;
	localparam int BP_IDX_W   = 4;

	typedef logic [1:0] ctr_t;

	// weakly not-taken
	localparam ctr_t CTR_RESET = 2'd1;

	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_PASS_NONE
	} alu_op_e;

	typedef enum logic [1:0] {
		FS_IDLE,
		FS_REQ,
		FS_RELEASE
	} fetch_state_e;

	//****************************************
	// stage records
	//****************************************
	typedef struct packed {
		logic                 valid;
		rv_isa_pkg::pc_t      pc;
		rv_isa_pkg::word_t    instr;
		logic                 pred_taken;
		rv_isa_pkg::pc_t      pred_npc;
	} fd_t;

	typedef struct packed {
		logic                 valid;
		rv_isa_pkg::pc_t      pc;
		rv_isa_pkg::word_t    rs1_val;
		rv_isa_pkg::word_t    rs2_val;
		rv_isa_pkg::imm_t     imm;
		rv_isa_pkg::reg_idx_t rd;
		logic                 we;
		alu_op_e              alu_op;
		logic                 is_branch;
		logic                 br_ne;
		logic                 pred_taken;
		rv_isa_pkg::pc_t      pred_npc;
	} de_t;

	typedef struct packed {
		logic                 valid;
		rv_isa_pkg::pc_t      pc;
		logic                 is_branch;
		logic                 pred_taken;
		logic                 taken;
		logic                 mispredict;
		rv_isa_pkg::reg_idx_t rd;
		logic                 we;
		rv_isa_pkg::word_t    wdata;
	} commit_t;

	typedef struct packed {
		logic                 valid;
		rv_isa_pkg::pc_t      target;
		logic                 train_valid;
		rv_isa_pkg::pc_t      train_pc;
		logic                 train_taken;
	} redirect_t;

endpackage

//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

	//****************************************
	// widths and vector types
	//****************************************
	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [XLEN-1:0] pc_t;
	typedef logic [XLEN-1:0] imm_t;
	typedef logic [4:0]      reg_idx_t;

	//****************************************
	// encodings of the kept instructions
	//****************************************
	// major opcodes
	localparam logic [6:0] OPC_OP     = 7'b011_0011;
	localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
	localparam logic [6:0] OPC_BRANCH = 7'b110_0011;

	// funct3, ADDI shares the ADD code
	localparam logic [2:0] F3_BEQ     = 3'b000;
	localparam logic [2:0] F3_BNE     = 3'b001;
	localparam logic [2:0] F3_ADD_SUB = 3'b000;

	// funct7 of SUB
	localparam logic [6:0] F7_SUB     = 7'b010_0000;

	// addi x0, x0, 0
	localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage
